//--- common/cache_reuse_pkg.sv
// Shared widths, line types and array classes for the read-path steering
// of the vertex cache reuse control block.
// Modules reach these definitions by scoped names.

package cache_reuse_pkg;

	////////////////////
	// Line widths
	////////////////////

	// Both widths include the class bit in the MSB
	localparam int cmd_line_w = 40;
	localparam int rsp_line_w = 24;

	typedef logic [cmd_line_w-1:0] cmd_line_t;
	typedef logic [rsp_line_w-1:0] rsp_line_t;

	////////////////////
	// Array classes
	////////////////////

	// Carried in the MSB of every command and response line
	typedef enum logic {
		class_job       = 1'b0,
		class_edge_data = 1'b1
	} array_class_e;

	////////////////////
	// Buffering
	////////////////////

	// Lines held per lane FIFO
	localparam int read_buffer_depth = 16;

endpackage

//--- common/lane_if.sv
// Connection between one lane FIFO and the channel arbiter.
// The FIFO presents its head on data with valid and empty, and the
// arbiter consumes the head by raising pop while valid is high.

interface lane_if #(
	parameter int line_w = 40
);

	// Head of the lane
	logic [line_w-1:0] data;
	logic              valid;
	logic              empty;

	// Consume head, next head shows after the edge
	logic              pop;

	modport fifo (
		output data,
		output valid,
		output empty,
		input  pop
	);

	modport arbiter (
		input  data,
		input  valid,
		input  empty,
		output pop
	);

endinterface

//--- read_channel/class_demux.sv
// Registered steering of incoming lines by array class.
// The MSB of each valid line selects the job lane or the edge-data lane,
// and the whole line is passed on with its class bit.

module class_demux #(
	parameter int line_w = 40
) (
	input  logic              clock,
	input  logic              rstn_internal,
	input  logic [line_w-1:0] line_in,
	input  logic              line_in_valid,
	output logic [line_w-1:0] job_line,
	output logic              job_push,
	output logic [line_w-1:0] edge_line,
	output logic              edge_push
);

	cache_reuse_pkg::array_class_e line_class;

	assign line_class = cache_reuse_pkg::array_class_e'(line_in[line_w-1]);

	// At most one push per valid line
	always_ff @(posedge clock or negedge rstn_internal) begin
		if (~rstn_internal) begin
			job_push  <= 1'b0;
			edge_push <= 1'b0;
		end else begin
			job_push  <= line_in_valid & (line_class == cache_reuse_pkg::class_job);
			edge_push <= line_in_valid & (line_class == cache_reuse_pkg::class_edge_data);
		end
	end

	always_ff @(posedge clock) begin
		if (line_in_valid && line_class == cache_reuse_pkg::class_job) begin
			job_line <= line_in;
		end
		if (line_in_valid && line_class == cache_reuse_pkg::class_edge_data) begin
			edge_line <= line_in;
		end
	end

endmodule

//--- read_channel/lane_fifo.sv
// First-word-fall-through FIFO for the lines of one lane.
// The head is presented on the lane interface as soon as it is written,
// and a pop while valid advances to the next entry on the following edge.

module lane_fifo #(
	parameter int line_w       = 40,
	parameter int buffer_depth = 16
) (
	input  logic              clock,
	input  logic              rstn_internal,
	input  logic              push,
	input  logic [line_w-1:0] data_in,
	lane_if.fifo              lane
);

	localparam int ptr_w = (buffer_depth > 1) ? $clog2(buffer_depth) : 1;
	localparam int cnt_w = $clog2(buffer_depth + 1);

	logic [line_w-1:0] mem [0:buffer_depth-1];
	logic [ptr_w-1:0]  wr_ptr;
	logic [ptr_w-1:0]  rd_ptr;
	logic [cnt_w-1:0]  count;
	logic              do_pop;

	// Wrap for depths that are not a power of two
	function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
		if (ptr == ptr_w'(buffer_depth - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign do_pop = lane.pop & lane.valid;

	always_ff @(posedge clock) begin
		if (push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	always_ff @(posedge clock or negedge rstn_internal) begin
		if (~rstn_internal) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			// Simultaneous push and pop keeps the count
			case ({push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign lane.data  = mem[rd_ptr];
	assign lane.valid = (count != '0);
	assign lane.empty = (count == '0);

endmodule

//--- read_channel/round_robin_arbiter.sv
// Two-way round-robin merge of the job lane and the edge-data lane.
// One nonempty lane is granted per cycle while draining is allowed, its
// head is popped and registered onto the output.

module round_robin_arbiter #(
	parameter int line_w = 40
) (
	input  logic              clock,
	input  logic              rstn_internal,
	input  logic              drain_allowed,
	lane_if.arbiter           job_lane,
	lane_if.arbiter           edge_lane,
	output logic [line_w-1:0] line_out,
	output logic              line_out_valid
);

	cache_reuse_pkg::array_class_e last_grant;
	cache_reuse_pkg::array_class_e grant_class;
	logic                          job_req;
	logic                          edge_req;
	logic                          grant;

	assign job_req  = drain_allowed & ~job_lane.empty;
	assign edge_req = drain_allowed & ~edge_lane.empty;
	assign grant    = job_req | edge_req;

	// On contention the lane not served last wins
	always_comb begin
		if (job_req && edge_req) begin
			grant_class = (last_grant == cache_reuse_pkg::class_job) ?
				cache_reuse_pkg::class_edge_data : cache_reuse_pkg::class_job;
		end else if (edge_req) begin
			grant_class = cache_reuse_pkg::class_edge_data;
		end else begin
			grant_class = cache_reuse_pkg::class_job;
		end
	end

	assign job_lane.pop  = grant & (grant_class == cache_reuse_pkg::class_job);
	assign edge_lane.pop = grant & (grant_class == cache_reuse_pkg::class_edge_data);

	always_ff @(posedge clock or negedge rstn_internal) begin
		if (~rstn_internal) begin
			// Job lane wins the first contention
			last_grant     <= cache_reuse_pkg::class_edge_data;
			line_out_valid <= 1'b0;
		end else begin
			line_out_valid <= (job_lane.pop & job_lane.valid) |
				(edge_lane.pop & edge_lane.valid);
			if (grant) begin
				last_grant <= grant_class;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (grant) begin
			line_out <= (grant_class == cache_reuse_pkg::class_edge_data) ?
				edge_lane.data : job_lane.data;
		end
	end

endmodule

//--- read_channel/read_channel.sv
// One read channel of the reuse control block.
// Lines are steered by class into a job lane and an edge-data lane,
// buffered per lane and merged back by a round-robin arbiter.
// The top level sets line_w per channel and passes buffer_depth down.

module read_channel #(
	parameter int line_w       = 40,
	parameter int buffer_depth = 16
) (
	input  logic              clock,
	input  logic              rstn_internal,
	input  logic [line_w-1:0] line_in,
	input  logic              line_in_valid,
	input  logic              drain_allowed,
	output logic [line_w-1:0] line_out,
	output logic              line_out_valid
);

	logic [line_w-1:0] job_line;
	logic              job_push;
	logic [line_w-1:0] edge_line;
	logic              edge_push;

	lane_if #(.line_w(line_w)) job_lane ();
	lane_if #(.line_w(line_w)) edge_lane ();

	////////////////////
	// Steering
	////////////////////

	class_demux #(.line_w(line_w)) i_class_demux (
		.clock        (clock),
		.rstn_internal(rstn_internal),
		.line_in      (line_in),
		.line_in_valid(line_in_valid),
		.job_line     (job_line),
		.job_push     (job_push),
		.edge_line    (edge_line),
		.edge_push    (edge_push)
	);

	////////////////////
	// Lane buffers
	////////////////////

	lane_fifo #(.line_w(line_w), .buffer_depth(buffer_depth)) i_job_fifo (
		.clock        (clock),
		.rstn_internal(rstn_internal),
		.push         (job_push),
		.data_in      (job_line),
		.lane         (job_lane.fifo)
	);

	lane_fifo #(.line_w(line_w), .buffer_depth(buffer_depth)) i_edge_fifo (
		.clock        (clock),
		.rstn_internal(rstn_internal),
		.push         (edge_push),
		.data_in      (edge_line),
		.lane         (edge_lane.fifo)
	);

	////////////////////
	// Merge
	////////////////////

	round_robin_arbiter #(.line_w(line_w)) i_arbiter (
		.clock         (clock),
		.rstn_internal (rstn_internal),
		.drain_allowed (drain_allowed),
		.job_lane      (job_lane.arbiter),
		.edge_lane     (edge_lane.arbiter),
		.line_out      (line_out),
		.line_out_valid(line_out_valid)
	);

endmodule

//--- rtl/vertex_cache_reuse_control.sv
// Read-path steering and merge of the vertex cache reuse control block.
// Read commands and read responses each pass through their own channel,
// where job lines and edge-data lines are buffered apart and merged again.
// Lanes drain only while enabled and the read buffer is not almost full.

module vertex_cache_reuse_control #(
	parameter int buffer_depth = cache_reuse_pkg::read_buffer_depth
) (
	input  logic                       clock,
	input  logic                       rstn_in,
	input  logic                       enabled_in,
	input  cache_reuse_pkg::cmd_line_t cmd_in,
	input  logic                       cmd_in_valid,
	input  cache_reuse_pkg::rsp_line_t rsp_in,
	input  logic                       rsp_in_valid,
	input  logic                       read_buffer_alfull,
	output cache_reuse_pkg::cmd_line_t cmd_out,
	output logic                       cmd_out_valid,
	output cache_reuse_pkg::rsp_line_t rsp_out,
	output logic                       rsp_out_valid
);

	logic                       rstn_internal;
	logic                       enabled;
	logic                       alfull;
	logic                       drain_allowed;
	cache_reuse_pkg::cmd_line_t cmd_in_q;
	logic                       cmd_in_valid_q;
	cache_reuse_pkg::rsp_line_t rsp_in_q;
	logic                       rsp_in_valid_q;
	cache_reuse_pkg::cmd_line_t cmd_merged;
	logic                       cmd_merged_valid;
	cache_reuse_pkg::rsp_line_t rsp_merged;
	logic                       rsp_merged_valid;

	////////////////////
	// Reset and control
	////////////////////

	always_ff @(posedge clock or negedge rstn_in) begin
		if (~rstn_in) begin
			rstn_internal <= 1'b0;
		end else begin
			rstn_internal <= 1'b1;
		end
	end

	// Drain permission lags the inputs by two edges
	always_ff @(posedge clock or negedge rstn_internal) begin
		if (~rstn_internal) begin
			enabled       <= 1'b0;
			alfull        <= 1'b0;
			drain_allowed <= 1'b0;
			cmd_in_valid_q <= 1'b0;
			rsp_in_valid_q <= 1'b0;
			cmd_out_valid  <= 1'b0;
			rsp_out_valid  <= 1'b0;
		end else begin
			enabled        <= enabled_in;
			alfull         <= read_buffer_alfull;
			drain_allowed  <= enabled & ~alfull;
			cmd_in_valid_q <= cmd_in_valid;
			rsp_in_valid_q <= rsp_in_valid;
			cmd_out_valid  <= cmd_merged_valid;
			rsp_out_valid  <= rsp_merged_valid;
		end
	end

	// Line payloads
	always_ff @(posedge clock) begin
		cmd_in_q <= cmd_in;
		rsp_in_q <= rsp_in;
		cmd_out  <= cmd_merged;
		rsp_out  <= rsp_merged;
	end

	////////////////////
	// Channels
	////////////////////

	read_channel #(
		.line_w      (cache_reuse_pkg::cmd_line_w),
		.buffer_depth(buffer_depth)
	) i_cmd_channel (
		.clock         (clock),
		.rstn_internal (rstn_internal),
		.line_in       (cmd_in_q),
		.line_in_valid (cmd_in_valid_q),
		.drain_allowed (drain_allowed),
		.line_out      (cmd_merged),
		.line_out_valid(cmd_merged_valid)
	);

	read_channel #(
		.line_w      (cache_reuse_pkg::rsp_line_w),
		.buffer_depth(buffer_depth)
	) i_rsp_channel (
		.clock         (clock),
		.rstn_internal (rstn_internal),
		.line_in       (rsp_in_q),
		.line_in_valid (rsp_in_valid_q),
		.drain_allowed (drain_allowed),
		.line_out      (rsp_merged),
		.line_out_valid(rsp_merged_valid)
	);

endmodule

//--- tests/tb_clock_gen.sv
// Clock and reset source for the testbench.
// Reset is held low for the given number of rising edges and
// released on the falling edge that follows.

module tb_clock_gen #(
	parameter int period       = 100,
	parameter int reset_cycles = 2
) (
	output logic clock,
	output logic rstn
);

	initial begin
		clock = 1'b0;
		forever #(period / 2) clock = ~clock;
	end

	initial begin
		rstn = 1'b0;
		repeat (reset_cycles) @(posedge clock);
		@(negedge clock);
		rstn = 1'b1;
	end

endmodule

//--- tests/tb_vertex_cache_reuse_control.sv
// Testbench for the vertex cache reuse control block.
// Random command and response lines run through both channels, followed by
// phases with the read buffer almost full, lane fairness and disabled drain.
// Each channel keeps one expected queue per class, and assertions compare.

module tb_vertex_cache_reuse_control;

	localparam int depth         = cache_reuse_pkg::read_buffer_depth;
	localparam int cmd_w         = cache_reuse_pkg::cmd_line_w;
	localparam int rsp_w         = cache_reuse_pkg::rsp_line_w;
	localparam int random_cycles = 200;
	// Longest wait for the queued lines of both lanes to come out
	localparam int drain_limit   = 4 * depth + 20;
	// Driven cycles over all phases, idle gaps included
	localparam int stim_cycles   = random_cycles + 4 * depth + 40;
	localparam int cycle_limit   = 4 * stim_cycles + 200;

	logic                          clock;
	logic                          rstn;
	logic                          rstn_d = 1'b0;
	logic                          enabled_in;
	logic                          read_buffer_alfull;
	cache_reuse_pkg::cmd_line_t    cmd_in;
	logic                          cmd_in_valid;
	cache_reuse_pkg::rsp_line_t    rsp_in;
	logic                          rsp_in_valid;
	cache_reuse_pkg::cmd_line_t    cmd_out;
	logic                          cmd_out_valid;
	cache_reuse_pkg::rsp_line_t    rsp_out;
	logic                          rsp_out_valid;

	cache_reuse_pkg::cmd_line_t    cmd_job_q[$];
	cache_reuse_pkg::cmd_line_t    cmd_edge_q[$];
	cache_reuse_pkg::rsp_line_t    rsp_job_q[$];
	cache_reuse_pkg::rsp_line_t    rsp_edge_q[$];
	cache_reuse_pkg::cmd_line_t    cmd_exp;
	cache_reuse_pkg::cmd_line_t    cmd_got;
	cache_reuse_pkg::rsp_line_t    rsp_exp;
	cache_reuse_pkg::rsp_line_t    rsp_got;
	logic                          cmd_extra = 1'b0;
	logic                          rsp_extra = 1'b0;
	logic                          cmd_alt_ok = 1'b1;
	logic                          rsp_alt_ok = 1'b1;
	cache_reuse_pkg::array_class_e cmd_prev;
	cache_reuse_pkg::array_class_e rsp_prev;
	logic                          cmd_prev_known = 1'b0;
	logic                          rsp_prev_known = 1'b0;
	logic                          fair_phase = 1'b0;
	logic [3:0]                    alfull_hist = '0;
	logic [3:0]                    disabled_hist = 4'hf;
	string                         test_name = "reset";
	int                            value_errors = 0;
	int                            other_errors = 0;
	int                            leftover = 0;
	int                            cycles = 0;

	tb_clock_gen #(.period(100), .reset_cycles(2)) i_clock_gen (
		.clock(clock),
		.rstn (rstn)
	);

	vertex_cache_reuse_control #(.buffer_depth(depth)) i_dut (
		.clock             (clock),
		.rstn_in           (rstn),
		.enabled_in        (enabled_in),
		.cmd_in            (cmd_in),
		.cmd_in_valid      (cmd_in_valid),
		.rsp_in            (rsp_in),
		.rsp_in_valid      (rsp_in_valid),
		.read_buffer_alfull(read_buffer_alfull),
		.cmd_out           (cmd_out),
		.cmd_out_valid     (cmd_out_valid),
		.rsp_out           (rsp_out),
		.rsp_out_valid     (rsp_out_valid)
	);

	////////////////////
	// Monitors
	////////////////////

	// Accepted lines go to the class queues and gating inputs to the history
	always @(posedge clock) begin : input_monitor
		rstn_d        <= rstn;
		alfull_hist   <= {alfull_hist[2:0], read_buffer_alfull};
		disabled_hist <= {disabled_hist[2:0], ~enabled_in};
		if (cmd_in_valid && cmd_in[cmd_w-1]) begin
			cmd_edge_q.push_back(cmd_in);
		end else if (cmd_in_valid) begin
			cmd_job_q.push_back(cmd_in);
		end
		if (rsp_in_valid && rsp_in[rsp_w-1]) begin
			rsp_edge_q.push_back(rsp_in);
		end else if (rsp_in_valid) begin
			rsp_job_q.push_back(rsp_in);
		end
	end

	// Outputs are stable here and expectations hold until the next falling edge
	always @(negedge clock) begin : cmd_scoreboard
		cache_reuse_pkg::array_class_e cls;
		cls = cache_reuse_pkg::array_class_e'(cmd_out[cmd_w-1]);
		if (cmd_out_valid) begin
			cmd_got    = cmd_out;
			cmd_alt_ok = !(fair_phase && cmd_prev_known && cmd_prev == cls &&
				cmd_job_q.size() > 0 && cmd_edge_q.size() > 0);
			if (cls == cache_reuse_pkg::class_job) begin
				cmd_extra = (cmd_job_q.size() == 0);
				if (!cmd_extra) begin
					cmd_exp = cmd_job_q.pop_front();
				end
			end else begin
				cmd_extra = (cmd_edge_q.size() == 0);
				if (!cmd_extra) begin
					cmd_exp = cmd_edge_q.pop_front();
				end
			end
			cmd_prev = cls;
		end
		cmd_prev_known = fair_phase && (cmd_prev_known || cmd_out_valid);
	end

	always @(negedge clock) begin : rsp_scoreboard
		cache_reuse_pkg::array_class_e cls;
		cls = cache_reuse_pkg::array_class_e'(rsp_out[rsp_w-1]);
		if (rsp_out_valid) begin
			rsp_got    = rsp_out;
			rsp_alt_ok = !(fair_phase && rsp_prev_known && rsp_prev == cls &&
				rsp_job_q.size() > 0 && rsp_edge_q.size() > 0);
			if (cls == cache_reuse_pkg::class_job) begin
				rsp_extra = (rsp_job_q.size() == 0);
				if (!rsp_extra) begin
					rsp_exp = rsp_job_q.pop_front();
				end
			end else begin
				rsp_extra = (rsp_edge_q.size() == 0);
				if (!rsp_extra) begin
					rsp_exp = rsp_edge_q.pop_front();
				end
			end
			rsp_prev = cls;
		end
		rsp_prev_known = fair_phase && (rsp_prev_known || rsp_out_valid);
	end

	////////////////////
	// Assertions
	////////////////////

	assert property (@(posedge clock) (!rstn || !rstn_d) |-> !(cmd_out_valid || rsp_out_valid))
		else begin
			other_errors++;
			$display("Output valid seen during reset or on the first edge after it");
		end

	// Four edges from a sampled gating input to the output register
	assert property (@(posedge clock) alfull_hist[3] |-> !(cmd_out_valid || rsp_out_valid))
		else begin
			other_errors++;
			$display("Output valid while the read buffer was almost full in %s", test_name);
		end

	assert property (@(posedge clock) disabled_hist[3] |-> !(cmd_out_valid || rsp_out_valid))
		else begin
			other_errors++;
			$display("Output valid while the block was disabled in %s", test_name);
		end

	assert property (@(posedge clock) cmd_out_valid |-> !cmd_extra)
		else begin
			other_errors++;
			$display("Command line %h came out with none of its class pending", cmd_got);
		end

	assert property (@(posedge clock) cmd_out_valid && !cmd_extra |-> cmd_out == cmd_exp)
		else begin
			value_errors++;
			$display("ERR %s expected %h actual %h", test_name, cmd_exp, cmd_got);
		end

	assert property (@(posedge clock) cmd_out_valid |-> cmd_alt_ok)
		else begin
			other_errors++;
			$display("Command channel served one lane twice while both lanes held lines");
		end

	assert property (@(posedge clock) rsp_out_valid |-> !rsp_extra)
		else begin
			other_errors++;
			$display("Response line %h came out with none of its class pending", rsp_got);
		end

	assert property (@(posedge clock) rsp_out_valid && !rsp_extra |-> rsp_out == rsp_exp)
		else begin
			value_errors++;
			$display("ERR %s expected %h actual %h", test_name, rsp_exp, rsp_got);
		end

	assert property (@(posedge clock) rsp_out_valid |-> rsp_alt_ok)
		else begin
			other_errors++;
			$display("Response channel served one lane twice while both lanes held lines");
		end

	always @(posedge clock) begin : watchdog
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("Timeout after %0d cycles before the run could finish", cycles);
			$display("Errors: %0d value, %0d other", value_errors, other_errors);
			$display("Done: errors found");
			$finish;
		end
	end

	////////////////////
	// Stimulus
	////////////////////

	task automatic drive_cycle(input logic cmd_v, input logic rsp_v,
		input logic cmd_cls, input logic rsp_cls);
		@(negedge clock);
		cmd_in_valid         = cmd_v;
		rsp_in_valid         = rsp_v;
		cmd_in               = {8'($urandom()), 32'($urandom())};
		cmd_in[cmd_w-1]      = cmd_cls;
		rsp_in               = 24'($urandom());
		rsp_in[rsp_w-1]      = rsp_cls;
	endtask

	task automatic idle(input int n);
		repeat (n) drive_cycle(1'b0, 1'b0, 1'b0, 1'b0);
	endtask

	// Ends once every sent line has come out or the drain period is over
	task automatic wait_drain();
		int waited;
		waited = 0;
		idle(2);
		while (cmd_job_q.size() + cmd_edge_q.size() + rsp_job_q.size() +
			rsp_edge_q.size() != 0 && waited < drain_limit) begin
			idle(1);
			waited++;
		end
		idle(8);
	endtask

	initial begin
		void'($urandom(32'h123311ca));
		enabled_in         = 1'b0;
		read_buffer_alfull = 1'b0;
		cmd_in             = '0;
		cmd_in_valid       = 1'b0;
		rsp_in             = '0;
		rsp_in_valid       = 1'b0;
		wait (rstn);
		idle(2);
		enabled_in = 1'b1;

		test_name = "random_order";
		repeat (random_cycles) begin
			drive_cycle(1'($urandom()), 1'($urandom()), 1'($urandom()), 1'($urandom()));
		end
		wait_drain();

		test_name = "back_pressure";
		read_buffer_alfull = 1'b1;
		repeat (depth) drive_cycle(1'b1, 1'b1, 1'($urandom()), 1'($urandom()));
		idle(6);
		read_buffer_alfull = 1'b0;
		wait_drain();

		// Both lanes filled in class order, then released together
		test_name = "fairness";
		read_buffer_alfull = 1'b1;
		idle(4);
		repeat (depth) drive_cycle(1'b1, 1'b1, 1'b0, 1'b1);
		repeat (depth) drive_cycle(1'b1, 1'b1, 1'b1, 1'b0);
		idle(6);
		@(posedge clock);
		fair_phase = 1'b1;
		@(negedge clock);
		read_buffer_alfull = 1'b0;
		wait_drain();
		@(posedge clock);
		fair_phase = 1'b0;
		@(negedge clock);

		test_name = "enable_gating";
		enabled_in = 1'b0;
		repeat (depth) drive_cycle(1'b1, 1'b1, 1'($urandom()), 1'($urandom()));
		idle(6);
		enabled_in = 1'b1;
		wait_drain();

		leftover = cmd_job_q.size() + cmd_edge_q.size() + rsp_job_q.size() + rsp_edge_q.size();
		assert (leftover == 0)
			else $display("%0d lines were never delivered", leftover);
		$display("Errors: %0d value, %0d other, %0d undelivered",
			value_errors, other_errors, leftover);
		if (value_errors == 0 && other_errors == 0 && leftover == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

//--- compile.f
common/cache_reuse_pkg.sv
common/lane_if.sv
read_channel/class_demux.sv
read_channel/lane_fifo.sv
read_channel/round_robin_arbiter.sv
read_channel/read_channel.sv
rtl/vertex_cache_reuse_control.sv
tests/tb_clock_gen.sv
tests/tb_vertex_cache_reuse_control.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log for failure

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --assert -j 0 -f compile.f \
	--top-module tb_vertex_cache_reuse_control -o tb_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Done: errors found" "$log"; then
	exit 1
fi
exit 0
